// File: hw/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

	typedef logic [31:0] word_t;   // operand or one half of hi/lo
	typedef logic [63:0] dword_t;  // full product, or {hi, lo}
	typedef logic [5:0]  cnt_t;

	typedef enum logic [2:0]
	{
		op_mult,
		op_multu,
		op_div,
		op_divu,
		op_madd,
		op_maddu,
		op_msub,
		op_msubu
	} md_op_e;

	typedef enum logic [1:0]
	{
		st_idle,
		st_mul_run,
		st_div_run
	} ctrl_state_e;

	// accepting edge to result edge
	localparam cnt_t MUL_CYCLES = 6'd5;
	localparam cnt_t DIV_CYCLES = 6'd33;
	localparam cnt_t DIV_STEPS  = 6'd32;  // one quotient bit per step

	typedef struct packed
	{
		md_op_e op;
		word_t  a;
		word_t  b;
	} md_req_t;

	typedef struct packed
	{
		logic  en;
		logic  sel_hi;  // 1 = hi, 0 = lo
		word_t data;
	} hilo_wr_t;

endpackage

`default_nettype wire

// File: hw/muldiv_ctrl.sv
`default_nettype none

module muldiv_ctrl
	import muldiv_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   start,
	input  wire md_op_e op_in,
	input  wire logic   last,
	output logic        busy,
	output logic        load_mul,
	output logic        load_div,
	output logic        cnt_load,
	output cnt_t        cnt_len,
	output logic        commit,
	output md_op_e      op_held
);

	ctrl_state_e state;
	logic        accept;
	logic        is_div_req;

	// a start is only seen in idle, busy masks everything else
	assign accept     = (state == st_idle) && start;
	assign is_div_req = (op_in == op_div) || (op_in == op_divu);

	assign busy     = (state != st_idle);
	assign load_mul = accept && !is_div_req;
	assign load_div = accept && is_div_req;
	assign cnt_load = accept;
	assign cnt_len  = is_div_req ? DIV_CYCLES : MUL_CYCLES;
	assign commit   = busy && last;  // hi/lo update on the edge that ends the run

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state   <= st_idle;
			op_held <= op_mult;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (accept)
					begin
						op_held <= op_in;
						state   <= is_div_req ? st_div_run : st_mul_run;
					end
				end
				st_mul_run, st_div_run:
				begin
					if (last)
						state <= st_idle;
				end
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/muldiv_cycle_counter.sv
`default_nettype none

module muldiv_cycle_counter
	import muldiv_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic load,
	input  wire cnt_t len,
	output logic      last
);

	cnt_t count;
	logic running;

	assign last = running && (count == '0);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			count   <= '0;
			running <= 1'b0;
		end
		else if (load)
		begin
			count   <= len - 6'd1;  // zero is reached in the final cycle
			running <= 1'b1;
		end
		else if (running)
		begin
			if (count == '0)
				running <= 1'b0;
			else
				count <= count - 6'd1;
		end
	end

endmodule

`default_nettype wire

// File: hw/mul_array.sv
`default_nettype none

module mul_array
	import muldiv_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    load,
	input  wire md_req_t req,
	output dword_t       product
);

	word_t              a_q;
	word_t              b_q;
	logic               sgn_q;
	logic               pend;     // operands captured, product not yet
	logic signed [32:0] a_ext;
	logic signed [32:0] b_ext;
	logic signed [65:0] prod_full;

	// one extra bit turns both signed and unsigned into a signed multiply
	assign a_ext     = {sgn_q & a_q[31], a_q};
	assign b_ext     = {sgn_q & b_q[31], b_q};
	assign prod_full = a_ext * b_ext;

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			a_q   <= req.a;
			b_q   <= req.b;
			sgn_q <= (req.op == op_mult) || (req.op == op_madd) || (req.op == op_msub);
		end
		if (pend)
			product <= prod_full[63:0];
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			pend <= 1'b0;
		else
			pend <= load;
	end

endmodule

`default_nettype wire

// File: hw/div_iter.sv
`default_nettype none

module div_iter
	import muldiv_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    load,
	input  wire md_req_t req,
	output dword_t       result
);

	logic        sgn_in;
	word_t       a_mag;
	word_t       b_mag;
	word_t       dvsr_q;
	word_t       rem_q;
	word_t       quo_q;   // dividend shifts out the top, quotient bits in the bottom
	logic        neg_quo;
	logic        neg_rem;
	cnt_t        steps;
	logic [32:0] shifted;
	logic [32:0] diff;
	logic        borrow;
	word_t       quo_fix;
	word_t       rem_fix;

	assign sgn_in = (req.op == op_div);
	assign a_mag  = (sgn_in && req.a[31]) ? -req.a : req.a;
	assign b_mag  = (sgn_in && req.b[31]) ? -req.b : req.b;

	// one restoring step
	assign shifted = {rem_q, quo_q[31]};
	assign diff    = shifted - {1'b0, dvsr_q};
	assign borrow  = shifted < {1'b0, dvsr_q};

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			dvsr_q  <= b_mag;
			rem_q   <= '0;
			quo_q   <= a_mag;
			neg_quo <= sgn_in && (req.a[31] ^ req.b[31]);
			neg_rem <= sgn_in && req.a[31];  // remainder follows the dividend
		end
		else if (steps != '0)
		begin
			rem_q <= borrow ? shifted[31:0] : diff[31:0];
			quo_q <= {quo_q[30:0], ~borrow};
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			steps <= '0;
		else if (load)
			steps <= DIV_STEPS;
		else if (steps != '0)
			steps <= steps - 6'd1;
	end

	// divide by zero falls out of the loop as all-ones and the dividend
	assign quo_fix = neg_quo ? -quo_q : quo_q;
	assign rem_fix = neg_rem ? -rem_q : rem_q;
	assign result  = {rem_fix, quo_fix};

endmodule

`default_nettype wire

// File: hw/hilo_acc.sv
`default_nettype none

module hilo_acc
	import muldiv_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     commit,
	input  wire md_op_e   op,
	input  wire dword_t   product,
	input  wire dword_t   quotient_rem,
	input  wire hilo_wr_t wr,
	output word_t         hi,
	output word_t         lo
);

	dword_t hilo;

	assign hi = hilo[63:32];
	assign lo = hilo[31:0];

	always_ff @(posedge clk)
	begin
		if (!rst)
			hilo <= '0;
		else if (commit)  // a write on the same edge is dropped
		begin
			case (op)
				op_madd, op_maddu:
					hilo <= hilo + product;  // wraps at 64 bits
				op_msub, op_msubu:
					hilo <= hilo - product;
				op_div, op_divu:
					hilo <= quotient_rem;
				default:
					hilo <= product;
			endcase
		end
		else if (wr.en)
		begin
			if (wr.sel_hi)
				hilo[63:32] <= wr.data;
			else
				hilo[31:0] <= wr.data;
		end
	end

endmodule

`default_nettype wire

// File: hw/muldiv_unit.sv
`default_nettype none

module muldiv_unit
	import muldiv_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     start,
	input  wire md_req_t  req,
	input  wire hilo_wr_t wr,
	output logic          busy,
	output word_t         hi,
	output word_t         lo
);

	logic   load_mul;
	logic   load_div;
	logic   cnt_load;
	cnt_t   cnt_len;
	logic   last;
	logic   commit;
	md_op_e op_held;
	dword_t product;
	dword_t quotient_rem;

	muldiv_ctrl i_muldiv_ctrl
	(
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.op_in    (req.op),
		.last     (last),
		.busy     (busy),
		.load_mul (load_mul),
		.load_div (load_div),
		.cnt_load (cnt_load),
		.cnt_len  (cnt_len),
		.commit   (commit),
		.op_held  (op_held)
	);

	muldiv_cycle_counter i_muldiv_cycle_counter
	(
		.clk  (clk),
		.rst  (rst),
		.load (cnt_load),
		.len  (cnt_len),
		.last (last)
	);

	mul_array i_mul_array
	(
		.clk     (clk),
		.rst     (rst),
		.load    (load_mul),
		.req     (req),
		.product (product)
	);

	div_iter i_div_iter
	(
		.clk    (clk),
		.rst    (rst),
		.load   (load_div),
		.req    (req),
		.result (quotient_rem)
	);

	hilo_acc i_hilo_acc
	(
		.clk          (clk),
		.rst          (rst),
		.commit       (commit),
		.op           (op_held),
		.product      (product),
		.quotient_rem (quotient_rem),
		.wr           (wr),
		.hi           (hi),
		.lo           (lo)
	);

endmodule

`default_nettype wire

// File: verification/muldiv_chk.sv
`default_nettype none

module muldiv_chk
	import muldiv_pkg::*;
(
	input wire logic     clk,
	input wire logic     rst,
	input wire logic     start,
	input wire md_req_t  req,
	input wire hilo_wr_t wr,
	input wire logic     busy,
	input wire word_t    hi,
	input wire word_t    lo
);
	timeunit 1ns;
	timeprecision 100ps;

	logic div_req;
	logic accept_mul;
	logic accept_div;
	int   fail_count = 0;  // failed assertions so far

	assign div_req    = (req.op == op_div) || (req.op == op_divu);
	assign accept_mul = start && !busy && !div_req;
	assign accept_div = start && !busy && div_req;

	busy_after_reset: assert property (@(posedge clk) !rst |=> !busy)
		else
		begin
			fail_count++;
			$error("busy still high one cycle after reset");
		end

	busy_after_accept: assert property (@(posedge clk) disable iff (!rst)
		(start && !busy) |=> busy)
		else
		begin
			fail_count++;
			$error("busy did not rise after an accepted start");
		end

	// nothing may touch hi/lo when idle without a write
	hilo_quiet: assert property (@(posedge clk) disable iff (!rst)
		(!busy && !wr.en) |=> ($stable(hi) && $stable(lo)))
		else
		begin
			fail_count++;
			$error("hi/lo changed with no commit and no direct write");
		end

	// fall is seen one sample after the edge that clears busy
	busy_latency: assert property (@(posedge clk) disable iff (!rst)
		$fell(busy) |-> ($past(accept_mul, MUL_CYCLES + 1)
			|| $past(accept_div, DIV_CYCLES + 1)))
		else
		begin
			fail_count++;
			$error("busy fell at the wrong cycle for the operation class");
		end

endmodule

`default_nettype wire

// File: verification/muldiv_tb.sv
`default_nettype none

module muldiv_tb
	import muldiv_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int OP_COUNT    = 55;
	localparam int WATCHDOG_NS = OP_COUNT * (int'(DIV_CYCLES) + 4) * 20 + 200 * 20;

	logic     clk;
	logic     rst;
	logic     start;
	md_req_t  req;
	hilo_wr_t wr;
	logic     busy;
	word_t    hi;
	word_t    lo;
	dword_t   model_hilo;  // expected {hi, lo}

	muldiv_unit i_muldiv_unit
	(
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.req   (req),
		.wr    (wr),
		.busy  (busy),
		.hi    (hi),
		.lo    (lo)
	);

	bind muldiv_unit muldiv_chk i_muldiv_chk
	(
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.req   (req),
		.wr    (wr),
		.busy  (busy),
		.hi    (hi),
		.lo    (lo)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL %s: expected %h, got %h", name, expected, actual));
	endtask

	task automatic compare_count(input string name, input int expected, input int actual);
		if (actual != expected)
			abort_run($sformatf("FAIL %s: expected %0h, got %0h", name, expected, actual));
	endtask

	function automatic logic is_div(input md_op_e op);
		return (op == op_div) || (op == op_divu);
	endfunction

	function automatic int expected_latency(input md_op_e op);
		return is_div(op) ? int'(DIV_CYCLES) : int'(MUL_CYCLES);
	endfunction

	function automatic dword_t expected_product(input md_op_e op, input word_t a, input word_t b);
		dword_t ax;
		dword_t bx;
		if (op == op_mult || op == op_madd || op == op_msub)
		begin
			ax = {{32{a[31]}}, a};  // sign extended, low 64 bits are exact
			bx = {{32{b[31]}}, b};
		end
		else
		begin
			ax = {32'h0, a};
			bx = {32'h0, b};
		end
		return ax * bx;
	endfunction

	// {remainder, quotient} with rounding toward zero
	function automatic dword_t expected_divide(input md_op_e op, input word_t a, input word_t b);
		word_t q;
		word_t r;
		if (op == op_div)
		begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end
		else if (b == '0)
		begin
			q = '1;
			r = a;
		end
		else
		begin
			q = a / b;
			r = a % b;
		end
		return {r, q};
	endfunction

	task automatic apply_to_model(input md_op_e op, input word_t a, input word_t b);
		dword_t prod;
		prod = expected_product(op, a, b);
		case (op)
			op_madd, op_maddu: model_hilo = model_hilo + prod;
			op_msub, op_msubu: model_hilo = model_hilo - prod;
			op_div, op_divu:   model_hilo = expected_divide(op, a, b);
			default:           model_hilo = prod;
		endcase
	endtask

	task automatic check_hilo(input string tag);
		compare_word({"hi after ", tag}, model_hilo[63:32], hi);
		compare_word({"lo after ", tag}, model_hilo[31:0], lo);
	endtask

	task automatic set_req(input md_op_e op, input word_t a, input word_t b);
		req.op <= op;
		req.a  <= a;
		req.b  <= b;
	endtask

	// returns on the accepting edge
	task automatic drive_start(input md_op_e op, input word_t a, input word_t b);
		@(posedge clk);
		start <= 1'b1;
		set_req(op, a, b);
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (busy)
		begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic run_and_check(input md_op_e op, input word_t a, input word_t b);
		int cycles;
		apply_to_model(op, a, b);
		drive_start(op, a, b);
		wait_done(cycles);
		compare_count($sformatf("latency of %s", op.name()), expected_latency(op), cycles);
		check_hilo(op.name());
	endtask

	task automatic direct_write(input logic sel_hi, input word_t data);
		@(posedge clk);
		wr.en     <= 1'b1;
		wr.sel_hi <= sel_hi;
		wr.data   <= data;
		@(posedge clk);
		wr.en <= 1'b0;
		@(negedge clk);
		if (sel_hi)
			model_hilo[63:32] = data;
		else
			model_hilo[31:0] = data;
		check_hilo("direct write");
	endtask

	task automatic test_reset_and_writes();
		if (busy !== 1'b0)
			abort_run("busy is high after reset");
		compare_word("hi after reset", '0, hi);
		compare_word("lo after reset", '0, lo);
		direct_write(1'b1, $urandom());
		direct_write(1'b0, $urandom());
	endtask

	task automatic test_multiply();
		word_t  edge_a[5];
		word_t  edge_b[5];
		md_op_e op;
		edge_a = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};
		edge_b = '{32'h1234_5678, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};
		for (int s = 0; s < 2; s++)
		begin
			if (s == 0)
				op = op_mult;
			else
				op = op_multu;
			for (int i = 0; i < 5; i++)
				run_and_check(op, edge_a[i], edge_b[i]);
			for (int i = 0; i < 6; i++)
				run_and_check(op, $urandom(), $urandom());
		end
	endtask

	task automatic test_accumulate();
		md_op_e acc_ops[4];
		acc_ops = '{op_madd, op_maddu, op_msub, op_msubu};
		for (int i = 0; i < 4; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				direct_write(1'b1, $urandom());  // preset
				direct_write(1'b0, $urandom());
				run_and_check(acc_ops[i], $urandom(), $urandom());
			end
		end
		direct_write(1'b1, '1);
		direct_write(1'b0, '1);
		run_and_check(op_maddu, 32'h1, 32'h1);  // wraps to zero
		run_and_check(op_msubu, 32'h1, 32'h1);
	endtask

	task automatic test_divide();
		word_t sa[6];
		word_t sb[6];
		word_t a;
		word_t b;
		sa = '{100, -100, 100, -100, 7, 32'h8000_0000};
		sb = '{7, 7, -7, -7, -100, 3};
		for (int i = 0; i < 6; i++)
			run_and_check(op_div, sa[i], sb[i]);
		for (int i = 0; i < 6; i++)
		begin
			a = $urandom();
			b = $urandom() >> ($urandom() % 28);
			if (b == '0 || b == '1)
				b = 32'h5;  // no zero, no overflow case
			if (i < 3)
				run_and_check(op_div, a, b);
			else
				run_and_check(op_divu, a, b);
		end
		run_and_check(op_divu, 32'hffff_ffff, 32'h1);
		run_and_check(op_divu, 32'h9e37_79b9, 32'h0);
	endtask

	task automatic test_busy_ignored();
		word_t a;
		word_t b;
		int    cycles;
		a = $urandom();
		b = $urandom();
		apply_to_model(op_mult, a, b);
		drive_start(op_mult, a, b);
		@(posedge clk);
		@(posedge clk);
		start <= 1'b1;  // second request in the middle of the run
		set_req(op_divu, ~a, 32'h3);
		@(posedge clk);
		start <= 1'b0;
		wait_done(cycles);
		compare_count("latency with a start during busy", expected_latency(op_mult), cycles + 3);
		check_hilo("ignored start");
		repeat (2) @(negedge clk);
		if (busy)
			abort_run("a start raised during busy was accepted later");
	endtask

	task automatic test_back_to_back();
		md_op_e ops[4];
		word_t  as[4];
		word_t  bs[4];
		int     cycles;
		ops = '{op_multu, op_div, op_msub, op_divu};
		for (int i = 0; i < 4; i++)
		begin
			as[i] = $urandom();
			bs[i] = ($urandom() >> 4) | 32'h1;
		end
		@(posedge clk);
		start <= 1'b1;
		set_req(ops[0], as[0], bs[0]);
		for (int i = 0; i < 4; i++)
		begin
			@(posedge clk);  // accepting edge, first one with busy low
			if (i < 3)
				set_req(ops[i + 1], as[i + 1], bs[i + 1]);
			else
				start <= 1'b0;
			apply_to_model(ops[i], as[i], bs[i]);
			wait_done(cycles);
			compare_count($sformatf("back-to-back latency of %s", ops[i].name()),
				expected_latency(ops[i]), cycles);
			check_hilo({"back-to-back ", ops[i].name()});
		end
	endtask

	// any failed bound assertion ends the run at once
	always @(i_muldiv_unit.i_muldiv_chk.fail_count)
	begin
		if (i_muldiv_unit.i_muldiv_chk.fail_count != 0)
			abort_run("an assertion in the bound checker failed");
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog timeout, the unit stopped responding");
	end

	initial
	begin
		void'($urandom(32'h8366_11ae));
		clk        = 1'b0;
		rst        = 1'b0;
		start      = 1'b0;
		req        = '0;
		wr         = '0;
		model_hilo = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		test_reset_and_writes();
		test_multiply();
		test_accumulate();
		test_divide();
		test_busy_ignored();
		test_back_to_back();
		if (i_muldiv_unit.i_muldiv_chk.fail_count == 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			abort_run("an assertion in the bound checker failed");
	end

endmodule

`default_nettype wire

// File: src.f
hw/muldiv_pkg.sv
hw/muldiv_ctrl.sv
hw/muldiv_cycle_counter.sv
hw/mul_array.sv
hw/div_iter.sv
hw/hilo_acc.sv
hw/muldiv_unit.sv
verification/muldiv_chk.sv
verification/muldiv_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module muldiv_tb -Mdir obj_dir
	./obj_dir/Vmuldiv_tb 2>&1 | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
